/* ex_pkg.sv */
package ex_pkg;

    // data and address word
    typedef logic [31:0] word_t;

    // architectural register index
    typedef logic [4:0] reg_idx_t;

    // shift amount, taken from the low bits of operand b
    typedef logic [4:0] shamt_t;

    // r0 reads as zero and is never forwarded
    localparam reg_idx_t ZERO_REG = 5'd0;

    // byte distance to the next instruction
    localparam word_t INST_STEP = 32'd4;

    // mem, ex2 and wb
    localparam int FWD_STAGES = 3;

    // integer ALU operations
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLT    = 4'd2,
        ALU_SLTU   = 4'd3,
        ALU_AND    = 4'd4,
        ALU_OR     = 4'd5,
        ALU_XOR    = 4'd6,
        ALU_NOR    = 4'd7,
        ALU_SLL    = 4'd8,
        ALU_SRL    = 4'd9,
        ALU_SRA    = 4'd10,
        // lui-style, forwards operand b
        ALU_PASS_B = 4'd11
    } alu_op_e;

    // flow operations
    typedef enum logic [3:0] {
        BR_NONE = 4'd0,
        BR_BEQ  = 4'd1,
        BR_BNE  = 4'd2,
        BR_BLT  = 4'd3,
        BR_BGE  = 4'd4,
        BR_BLTU = 4'd5,
        BR_BGEU = 4'd6,
        // pc-relative, always taken
        BR_B    = 4'd7,
        // rj plus imm, always taken
        BR_JIRL = 4'd8
    } br_op_e;

    // first ALU operand source
    typedef enum logic [1:0] {
        SRC1_RF   = 2'd0,
        SRC1_PC   = 2'd1,
        SRC1_ZERO = 2'd2
    } src1_sel_e;

    // second ALU operand source
    typedef enum logic {
        SRC2_RF  = 1'b0,
        SRC2_IMM = 1'b1
    } src2_sel_e;

endpackage

/* ex_alu.sv */
`timescale 1ns/1ns

module ex_alu
    import ex_pkg::*;
(
    input  alu_op_e op_i,
    input  word_t   a_i,
    input  word_t   b_i,
    output word_t   y_o
);

    shamt_t shamt;
    logic   lt_signed;
    logic   lt_unsigned;

    // only the low five bits shift
    assign shamt = b_i[4:0];

    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb begin
        case (op_i)
            ALU_ADD: begin
                y_o = a_i + b_i;
            end
            ALU_SUB: begin
                y_o = a_i - b_i;
            end
            ALU_SLT: begin
                y_o = {31'b0, lt_signed};
            end
            ALU_SLTU: begin
                y_o = {31'b0, lt_unsigned};
            end
            ALU_AND: begin
                y_o = a_i & b_i;
            end
            ALU_OR: begin
                y_o = a_i | b_i;
            end
            ALU_XOR: begin
                y_o = a_i ^ b_i;
            end
            ALU_NOR: begin
                y_o = ~(a_i | b_i);
            end
            ALU_SLL: begin
                y_o = a_i << shamt;
            end
            ALU_SRL: begin
                y_o = a_i >> shamt;
            end
            ALU_SRA: begin
                // arithmetic shift keeps the sign
                y_o = word_t'($signed(a_i) >>> shamt);
            end
            ALU_PASS_B: begin
                y_o = b_i;
            end
            default: begin
                y_o = '0;
            end
        endcase
    end

endmodule

/* ex_bypass.sv */
`timescale 1ns/1ns

module ex_bypass
    import ex_pkg::*;
(
    input  reg_idx_t rj_i,
    input  reg_idx_t rk_i,
    input  word_t    rj_data_i,
    input  word_t    rk_data_i,
    input  reg_idx_t mem_rd0_i, mem_rd1_i,
    input  reg_idx_t ex2_rd0_i, ex2_rd1_i,
    input  reg_idx_t wb_rd0_i, wb_rd1_i,
    input  word_t    mem_data0_i, mem_data1_i,
    input  word_t    ex2_data0_i, ex2_data1_i,
    input  word_t    wb_data0_i, wb_data1_i,
    input  logic     mem_vld0_i, mem_vld1_i,
    input  logic     ex2_vld0_i, ex2_vld1_i,
    input  logic     wb_vld0_i, wb_vld1_i,
    output word_t    rj_data_o,
    output word_t    rk_data_o,
    output logic     stall_o
);

    // candidates from newest to oldest, lane 1 ahead of lane 0 in each stage
    reg_idx_t cand_rd   [FWD_STAGES*2];
    word_t    cand_data [FWD_STAGES*2];
    logic     cand_vld  [FWD_STAGES*2];

    logic rj_stall;
    logic rk_stall;

    assign cand_rd   = '{mem_rd1_i, mem_rd0_i, ex2_rd1_i, ex2_rd0_i, wb_rd1_i, wb_rd0_i};
    assign cand_data = '{mem_data1_i, mem_data0_i, ex2_data1_i, ex2_data0_i,
                         wb_data1_i, wb_data0_i};
    assign cand_vld  = '{mem_vld1_i, mem_vld0_i, ex2_vld1_i, ex2_vld0_i, wb_vld1_i, wb_vld0_i};

    // first match in the list wins, a pending match stalls
    function automatic void pick_operand(
        input  reg_idx_t idx,
        input  word_t    rf_data,
        output word_t    data,
        output logic     stall
    );
        logic hit;
        hit   = 1'b0;
        data  = rf_data;
        stall = 1'b0;
        if (idx == ZERO_REG) begin
            data = '0;
        end else begin
            for (int i = 0; i < FWD_STAGES * 2; i++) begin
                if (!hit && cand_rd[i] == idx) begin
                    hit   = 1'b1;
                    data  = cand_data[i];
                    stall = !cand_vld[i];
                end
            end
        end
    endfunction

    always_comb begin
        pick_operand(rj_i, rj_data_i, rj_data_o, rj_stall);
        pick_operand(rk_i, rk_data_i, rk_data_o, rk_stall);
    end

    assign stall_o = rj_stall | rk_stall;

endmodule

/* ex_lane.sv */
`timescale 1ns/1ns

module ex_lane
    import ex_pkg::*;
(
    input  word_t     pc_i,
    input  word_t     imm_i,
    input  reg_idx_t  rj_i,
    input  reg_idx_t  rk_i,
    input  reg_idx_t  rd_i,
    input  word_t     rj_data_i,
    input  word_t     rk_data_i,
    input  alu_op_e   alu_op_i,
    input  br_op_e    br_op_i,
    input  src1_sel_e src1_sel_i,
    input  src2_sel_e src2_sel_i,
    input  logic      pred_taken_i,
    input  word_t     pred_target_i,
    input  reg_idx_t  mem_rd0_i, mem_rd1_i,
    input  reg_idx_t  ex2_rd0_i, ex2_rd1_i,
    input  reg_idx_t  wb_rd0_i, wb_rd1_i,
    input  word_t     mem_data0_i, mem_data1_i,
    input  word_t     ex2_data0_i, ex2_data1_i,
    input  word_t     wb_data0_i, wb_data1_i,
    input  logic      mem_vld0_i, mem_vld1_i,
    input  logic      ex2_vld0_i, ex2_vld1_i,
    input  logic      wb_vld0_i, wb_vld1_i,
    output word_t     result_o,
    output logic      result_wr_o,
    output logic      taken_o,
    output word_t     target_o,
    output logic      dir_fail_o,
    output logic      addr_fail_o,
    output logic      stall_o
);

    word_t rj_fwd;
    word_t rk_fwd;
    word_t alu_a;
    word_t alu_b;
    word_t alu_y;
    logic  is_branch;
    logic  is_link;
    logic  br_taken;

    ex_bypass i_bypass (
        .rj_i, .rk_i, .rj_data_i, .rk_data_i,
        .mem_rd0_i, .mem_rd1_i, .ex2_rd0_i, .ex2_rd1_i, .wb_rd0_i, .wb_rd1_i,
        .mem_data0_i, .mem_data1_i, .ex2_data0_i, .ex2_data1_i, .wb_data0_i, .wb_data1_i,
        .mem_vld0_i, .mem_vld1_i, .ex2_vld0_i, .ex2_vld1_i, .wb_vld0_i, .wb_vld1_i,
        .rj_data_o (rj_fwd),
        .rk_data_o (rk_fwd),
        .stall_o
    );

    always_comb begin
        case (src1_sel_i)
            SRC1_RF:   alu_a = rj_fwd;
            SRC1_PC:   alu_a = pc_i;
            default:   alu_a = '0;
        endcase
    end

    assign alu_b = (src2_sel_i == SRC2_IMM) ? imm_i : rk_fwd;

    ex_alu i_alu (
        .op_i (alu_op_i),
        .a_i  (alu_a),
        .b_i  (alu_b),
        .y_o  (alu_y)
    );

    // branch condition on the bypassed sources
    always_comb begin
        case (br_op_i)
            BR_BEQ:          br_taken = rj_fwd == rk_fwd;
            BR_BNE:          br_taken = rj_fwd != rk_fwd;
            BR_BLT:          br_taken = $signed(rj_fwd) < $signed(rk_fwd);
            BR_BGE:          br_taken = $signed(rj_fwd) >= $signed(rk_fwd);
            BR_BLTU:         br_taken = rj_fwd < rk_fwd;
            BR_BGEU:         br_taken = rj_fwd >= rk_fwd;
            BR_B, BR_JIRL:   br_taken = 1'b1;
            default:         br_taken = 1'b0;
        endcase
    end

    assign is_branch = br_op_i != BR_NONE;
    assign is_link   = (br_op_i == BR_B) || (br_op_i == BR_JIRL);

    assign taken_o  = br_taken;
    assign target_o = (br_op_i == BR_JIRL) ? rj_fwd + imm_i : pc_i + imm_i;

    // link value for b and jirl
    assign result_o    = is_branch ? pc_i + INST_STEP : alu_y;
    assign result_wr_o = (!is_branch || is_link) && (rd_i != ZERO_REG);

    assign dir_fail_o  = br_taken != pred_taken_i;
    assign addr_fail_o = br_taken && pred_taken_i && (target_o != pred_target_i);

endmodule

/* ex_resolve.sv */
`timescale 1ns/1ns

module ex_resolve
    import ex_pkg::*;
(
    input  logic     aclk,
    input  logic     aresetn,
    input  logic     issue_valid_i,
    input  word_t    pc0_i, pc1_i,
    input  reg_idx_t rd0_i, rd1_i,
    input  word_t    result0_i, result1_i,
    input  logic     result_wr0_i, result_wr1_i,
    input  logic     taken0_i, taken1_i,
    input  word_t    target0_i, target1_i,
    input  logic     dir_fail0_i, dir_fail1_i,
    input  logic     addr_fail0_i, addr_fail1_i,
    input  logic     stall0_i, stall1_i,
    output logic     forward_stall_o,
    output logic     res0_valid_o,
    output logic     res1_valid_o,
    output reg_idx_t rd0_o,
    output reg_idx_t rd1_o,
    output word_t    res0_o,
    output word_t    res1_o,
    output logic     flush_o,
    output word_t    redirect_pc_o
);

    logic     mispred0;
    logic     mispred1;
    logic     squash1;
    logic     flush;
    logic     accept;
    logic     valid0;
    logic     valid1;
    reg_idx_t rd1_kept;
    word_t    redirect_pc;

    assign mispred0 = dir_fail0_i | addr_fail0_i;
    assign mispred1 = dir_fail1_i | addr_fail1_i;

    // lane 1 sits on the wrong path once lane 0 leaves the fall-through
    assign squash1 = taken0_i | mispred0;
    assign flush   = mispred0 | (mispred1 & ~squash1);

    always_comb begin
        if (mispred0) begin
            redirect_pc = taken0_i ? target0_i : pc0_i + INST_STEP;
        end else begin
            redirect_pc = taken1_i ? target1_i : pc1_i + INST_STEP;
        end
    end

    assign forward_stall_o = issue_valid_i & (stall0_i | stall1_i);
    assign accept          = issue_valid_i & ~forward_stall_o;

    assign valid0   = result_wr0_i && (rd0_i != ZERO_REG);
    assign valid1   = result_wr1_i && !squash1 && (rd1_i != ZERO_REG);
    assign rd1_kept = squash1 ? ZERO_REG : rd1_i;

    // output register, cleared whenever no bundle is accepted
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            res0_valid_o  <= 1'b0;
            res1_valid_o  <= 1'b0;
            flush_o       <= 1'b0;
            rd0_o         <= ZERO_REG;
            rd1_o         <= ZERO_REG;
            res0_o        <= '0;
            res1_o        <= '0;
            redirect_pc_o <= '0;
        end else if (accept) begin
            res0_valid_o  <= valid0;
            res1_valid_o  <= valid1;
            flush_o       <= flush;
            rd0_o         <= rd0_i;
            rd1_o         <= rd1_kept;
            res0_o        <= result0_i;
            res1_o        <= result1_i;
            redirect_pc_o <= redirect_pc;
        end else begin
            res0_valid_o  <= 1'b0;
            res1_valid_o  <= 1'b0;
            flush_o       <= 1'b0;
            rd0_o         <= ZERO_REG;
            rd1_o         <= ZERO_REG;
            res0_o        <= '0;
            res1_o        <= '0;
            redirect_pc_o <= '0;
        end
    end

endmodule

/* ex_stage_top.sv */
`timescale 1ns/1ns

module ex_stage_top
    import ex_pkg::*;
(
    input  logic      aclk,
    input  logic      aresetn,
    input  logic      issue_valid_i,
    input  word_t     pc0_i, pc1_i,
    input  word_t     imm0_i, imm1_i,
    input  reg_idx_t  rj0_i, rj1_i,
    input  reg_idx_t  rk0_i, rk1_i,
    input  reg_idx_t  rd0_i, rd1_i,
    input  word_t     rj0_data_i, rj1_data_i,
    input  word_t     rk0_data_i, rk1_data_i,
    input  alu_op_e   alu_op0_i, alu_op1_i,
    input  br_op_e    br_op0_i, br_op1_i,
    input  src1_sel_e src1_sel0_i, src1_sel1_i,
    input  src2_sel_e src2_sel0_i, src2_sel1_i,
    input  logic      pred_taken0_i, pred_taken1_i,
    // one predicted target per bundle
    input  word_t     pred_target_i,
    input  reg_idx_t  mem_rd0_i, mem_rd1_i,
    input  reg_idx_t  ex2_rd0_i, ex2_rd1_i,
    input  reg_idx_t  wb_rd0_i, wb_rd1_i,
    input  word_t     mem_data0_i, mem_data1_i,
    input  word_t     ex2_data0_i, ex2_data1_i,
    input  word_t     wb_data0_i, wb_data1_i,
    input  logic      mem_vld0_i, mem_vld1_i,
    input  logic      ex2_vld0_i, ex2_vld1_i,
    input  logic      wb_vld0_i, wb_vld1_i,
    output logic      forward_stall_o,
    output logic      res0_valid_o,
    output logic      res1_valid_o,
    output reg_idx_t  rd0_o,
    output reg_idx_t  rd1_o,
    output word_t     res0_o,
    output word_t     res1_o,
    output logic      flush_o,
    output word_t     redirect_pc_o
);

    word_t result0, result1;
    logic  result_wr0, result_wr1;
    logic  taken0, taken1;
    word_t target0, target1;
    logic  dir_fail0, dir_fail1;
    logic  addr_fail0, addr_fail1;
    logic  stall0, stall1;

    ex_lane i_lane0 (
        .pc_i (pc0_i), .imm_i (imm0_i), .rj_i (rj0_i), .rk_i (rk0_i), .rd_i (rd0_i),
        .rj_data_i (rj0_data_i), .rk_data_i (rk0_data_i),
        .alu_op_i (alu_op0_i), .br_op_i (br_op0_i),
        .src1_sel_i (src1_sel0_i), .src2_sel_i (src2_sel0_i),
        .pred_taken_i (pred_taken0_i), .pred_target_i,
        .mem_rd0_i, .mem_rd1_i, .ex2_rd0_i, .ex2_rd1_i, .wb_rd0_i, .wb_rd1_i,
        .mem_data0_i, .mem_data1_i, .ex2_data0_i, .ex2_data1_i, .wb_data0_i, .wb_data1_i,
        .mem_vld0_i, .mem_vld1_i, .ex2_vld0_i, .ex2_vld1_i, .wb_vld0_i, .wb_vld1_i,
        .result_o (result0), .result_wr_o (result_wr0),
        .taken_o (taken0), .target_o (target0),
        .dir_fail_o (dir_fail0), .addr_fail_o (addr_fail0),
        .stall_o (stall0)
    );

    ex_lane i_lane1 (
        .pc_i (pc1_i), .imm_i (imm1_i), .rj_i (rj1_i), .rk_i (rk1_i), .rd_i (rd1_i),
        .rj_data_i (rj1_data_i), .rk_data_i (rk1_data_i),
        .alu_op_i (alu_op1_i), .br_op_i (br_op1_i),
        .src1_sel_i (src1_sel1_i), .src2_sel_i (src2_sel1_i),
        .pred_taken_i (pred_taken1_i), .pred_target_i,
        .mem_rd0_i, .mem_rd1_i, .ex2_rd0_i, .ex2_rd1_i, .wb_rd0_i, .wb_rd1_i,
        .mem_data0_i, .mem_data1_i, .ex2_data0_i, .ex2_data1_i, .wb_data0_i, .wb_data1_i,
        .mem_vld0_i, .mem_vld1_i, .ex2_vld0_i, .ex2_vld1_i, .wb_vld0_i, .wb_vld1_i,
        .result_o (result1), .result_wr_o (result_wr1),
        .taken_o (taken1), .target_o (target1),
        .dir_fail_o (dir_fail1), .addr_fail_o (addr_fail1),
        .stall_o (stall1)
    );

    ex_resolve i_resolve (
        .aclk, .aresetn, .issue_valid_i,
        .pc0_i, .pc1_i, .rd0_i, .rd1_i,
        .result0_i (result0), .result1_i (result1),
        .result_wr0_i (result_wr0), .result_wr1_i (result_wr1),
        .taken0_i (taken0), .taken1_i (taken1),
        .target0_i (target0), .target1_i (target1),
        .dir_fail0_i (dir_fail0), .dir_fail1_i (dir_fail1),
        .addr_fail0_i (addr_fail0), .addr_fail1_i (addr_fail1),
        .stall0_i (stall0), .stall1_i (stall1),
        .forward_stall_o, .res0_valid_o, .res1_valid_o,
        .rd0_o, .rd1_o, .res0_o, .res1_o,
        .flush_o, .redirect_pc_o
    );

endmodule

/* tb_ex_stage.sv */
`timescale 1ns/1ns

module tb_ex_stage
    import ex_pkg::*;
();

    localparam int N_DIRECTED = 273;
    localparam int N_RANDOM   = 400;
    localparam int MAX_CYCLES = 2 * (N_DIRECTED + N_RANDOM) + 200;

    logic      aclk;
    logic      aresetn;
    logic      issue_valid;
    word_t     pc [2];
    word_t     imm [2];
    reg_idx_t  rj [2];
    reg_idx_t  rk [2];
    reg_idx_t  rd [2];
    word_t     rj_data [2];
    word_t     rk_data [2];
    alu_op_e   alu_op [2];
    br_op_e    br_op [2];
    src1_sel_e src1_sel [2];
    src2_sel_e src2_sel [2];
    logic      pred_taken [2];
    word_t     pred_target;
    // bypass sources indexed by stage (mem ex2 wb) and then by lane
    reg_idx_t  byp_rd [3][2];
    word_t     byp_data [3][2];
    logic      byp_vld [3][2];

    logic      forward_stall_o, res0_valid_o, res1_valid_o, flush_o;
    reg_idx_t  rd0_o, rd1_o;
    word_t     res0_o, res1_o, redirect_pc_o;

    // reference model per lane and for the whole bundle
    word_t     m_res [2];
    word_t     m_tgt [2];
    logic      m_wr [2];
    logic      m_tk [2];
    logic      m_mis [2];
    logic      m_stl [2];
    logic      m_fstall, m_squash, m_flush;
    word_t     m_redirect;

    logic      exp_acc, exp_v0, exp_v1, exp_flush;
    reg_idx_t  exp_rd0, exp_rd1;
    word_t     exp_res0, exp_res1, exp_redirect;

    int errors  = 0;
    int bundles = 0;
    int stalls  = 0;
    int cycles  = 0;

    ex_stage_top i_dut (
        .aclk, .aresetn, .issue_valid_i (issue_valid),
        .pc0_i (pc[0]), .pc1_i (pc[1]), .imm0_i (imm[0]), .imm1_i (imm[1]),
        .rj0_i (rj[0]), .rj1_i (rj[1]), .rk0_i (rk[0]), .rk1_i (rk[1]),
        .rd0_i (rd[0]), .rd1_i (rd[1]),
        .rj0_data_i (rj_data[0]), .rj1_data_i (rj_data[1]),
        .rk0_data_i (rk_data[0]), .rk1_data_i (rk_data[1]),
        .alu_op0_i (alu_op[0]), .alu_op1_i (alu_op[1]),
        .br_op0_i (br_op[0]), .br_op1_i (br_op[1]),
        .src1_sel0_i (src1_sel[0]), .src1_sel1_i (src1_sel[1]),
        .src2_sel0_i (src2_sel[0]), .src2_sel1_i (src2_sel[1]),
        .pred_taken0_i (pred_taken[0]), .pred_taken1_i (pred_taken[1]),
        .pred_target_i (pred_target),
        .mem_rd0_i (byp_rd[0][0]), .mem_rd1_i (byp_rd[0][1]),
        .ex2_rd0_i (byp_rd[1][0]), .ex2_rd1_i (byp_rd[1][1]),
        .wb_rd0_i (byp_rd[2][0]), .wb_rd1_i (byp_rd[2][1]),
        .mem_data0_i (byp_data[0][0]), .mem_data1_i (byp_data[0][1]),
        .ex2_data0_i (byp_data[1][0]), .ex2_data1_i (byp_data[1][1]),
        .wb_data0_i (byp_data[2][0]), .wb_data1_i (byp_data[2][1]),
        .mem_vld0_i (byp_vld[0][0]), .mem_vld1_i (byp_vld[0][1]),
        .ex2_vld0_i (byp_vld[1][0]), .ex2_vld1_i (byp_vld[1][1]),
        .wb_vld0_i (byp_vld[2][0]), .wb_vld1_i (byp_vld[2][1]),
        .forward_stall_o, .res0_valid_o, .res1_valid_o, .rd0_o, .rd1_o,
        .res0_o, .res1_o, .flush_o, .redirect_pc_o
    );

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    function automatic word_t alu_ref(alu_op_e op, word_t a, word_t b);
        logic [63:0] ext;
        ext = {{32{a[31]}}, a} >> b[4:0];
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLT:  return {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
            ALU_SLTU: return {31'b0, a < b};
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_NOR:  return ~(a | b);
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return ext[31:0];
            default:  return b;
        endcase
    endfunction

    // newest stage first and lane 1 ahead of lane 0
    function automatic void fwd_ref(input reg_idx_t idx, input word_t rf,
                                    output word_t val, output logic stl);
        logic found;
        found = 1'b0;
        val   = rf;
        stl   = 1'b0;
        for (int s = 0; s < FWD_STAGES; s++) begin
            for (int l = 1; l >= 0; l--) begin
                if (!found && idx != ZERO_REG && byp_rd[s][l] == idx) begin
                    found = 1'b1;
                    val   = byp_data[s][l];
                    stl   = !byp_vld[s][l];
                end
            end
        end
        if (idx == ZERO_REG) begin
            val = '0;
        end
    endfunction

    function automatic void lane_ref(input int l, output word_t res, output logic wr,
                                     output logic tk, output word_t tgt,
                                     output logic mis, output logic stl);
        word_t x;
        word_t y;
        word_t a;
        word_t b;
        logic  sx;
        logic  sy;
        fwd_ref(rj[l], rj_data[l], x, sx);
        fwd_ref(rk[l], rk_data[l], y, sy);
        stl = sx | sy;
        a = (src1_sel[l] == SRC1_RF) ? x : (src1_sel[l] == SRC1_PC) ? pc[l] : '0;
        b = (src2_sel[l] == SRC2_IMM) ? imm[l] : y;
        case (br_op[l])
            BR_BEQ:  tk = x == y;
            BR_BNE:  tk = x != y;
            BR_BLT:  tk = $signed(x) < $signed(y);
            BR_BGE:  tk = !($signed(x) < $signed(y));
            BR_BLTU: tk = x < y;
            BR_BGEU: tk = !(x < y);
            BR_NONE: tk = 1'b0;
            default: tk = 1'b1;
        endcase
        tgt = ((br_op[l] == BR_JIRL) ? x : pc[l]) + imm[l];
        res = (br_op[l] == BR_NONE) ? alu_ref(alu_op[l], a, b) : pc[l] + INST_STEP;
        wr  = br_op[l] inside {BR_NONE, BR_B, BR_JIRL};
        mis = (tk != pred_taken[l]) || (tk && pred_taken[l] && tgt != pred_target);
    endfunction

    always_comb begin
        for (int l = 0; l < 2; l++) begin
            lane_ref(l, m_res[l], m_wr[l], m_tk[l], m_tgt[l], m_mis[l], m_stl[l]);
        end
        m_fstall = issue_valid && (m_stl[0] || m_stl[1]);
        m_squash = m_tk[0] || m_mis[0];
        m_flush  = m_mis[0] || (m_mis[1] && !m_squash);
        if (m_mis[0]) begin
            m_redirect = m_tk[0] ? m_tgt[0] : pc[0] + INST_STEP;
        end else begin
            m_redirect = m_tk[1] ? m_tgt[1] : pc[1] + INST_STEP;
        end
    end

    // expected outputs for the cycle after acceptance
    always_ff @(posedge aclk) begin
        exp_acc      <= aresetn && issue_valid && !m_fstall;
        exp_v0       <= aresetn && issue_valid && !m_fstall && m_wr[0] && rd[0] != ZERO_REG;
        exp_v1       <= aresetn && issue_valid && !m_fstall && m_wr[1] && !m_squash
                        && rd[1] != ZERO_REG;
        exp_flush    <= aresetn && issue_valid && !m_fstall && m_flush;
        exp_rd0      <= rd[0];
        exp_rd1      <= m_squash ? ZERO_REG : rd[1];
        exp_res0     <= m_res[0];
        exp_res1     <= m_res[1];
        exp_redirect <= m_redirect;
        if (aresetn && issue_valid && !m_fstall) begin
            bundles <= bundles + 1;
        end
    end

    task automatic fail_value(string name, logic [31:0] exp_val, logic [31:0] act_val);
        errors++;
        $display("Error: %s expected %h actual %h", name, exp_val, act_val);
    endtask

    a_fstall: assert property (@(posedge aclk) disable iff (!aresetn)
        forward_stall_o == m_fstall)
        else fail_value("forward_stall_o", $sampled(m_fstall), $sampled(forward_stall_o));
    a_v0: assert property (@(posedge aclk) disable iff (!aresetn) res0_valid_o == exp_v0)
        else fail_value("res0_valid_o", $sampled(exp_v0), $sampled(res0_valid_o));
    a_v1: assert property (@(posedge aclk) disable iff (!aresetn) res1_valid_o == exp_v1)
        else fail_value("res1_valid_o", $sampled(exp_v1), $sampled(res1_valid_o));
    a_flush: assert property (@(posedge aclk) disable iff (!aresetn) flush_o == exp_flush)
        else fail_value("flush_o", $sampled(exp_flush), $sampled(flush_o));
    a_rd0: assert property (@(posedge aclk) disable iff (!aresetn) exp_acc |-> rd0_o == exp_rd0)
        else fail_value("rd0_o", $sampled(exp_rd0), $sampled(rd0_o));
    a_rd1: assert property (@(posedge aclk) disable iff (!aresetn) exp_acc |-> rd1_o == exp_rd1)
        else fail_value("rd1_o", $sampled(exp_rd1), $sampled(rd1_o));
    a_res0: assert property (@(posedge aclk) disable iff (!aresetn)
        exp_acc |-> res0_o == exp_res0)
        else fail_value("res0_o", $sampled(exp_res0), $sampled(res0_o));
    a_res1: assert property (@(posedge aclk) disable iff (!aresetn)
        exp_acc |-> res1_o == exp_res1)
        else fail_value("res1_o", $sampled(exp_res1), $sampled(res1_o));
    a_redirect: assert property (@(posedge aclk) disable iff (!aresetn)
        exp_flush |-> redirect_pc_o == exp_redirect)
        else fail_value("redirect_pc_o", $sampled(exp_redirect), $sampled(redirect_pc_o));

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the stimulus did not finish", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // bypass sources only name r0 and are all valid
    task automatic clear_bypass();
        for (int s = 0; s < 3; s++) begin
            for (int l = 0; l < 2; l++) begin
                byp_rd[s][l]   <= ZERO_REG;
                byp_data[s][l] <= $urandom;
                byp_vld[s][l]  <= 1'b1;
            end
        end
    endtask

    task automatic set_lane(int l, alu_op_e op, br_op_e br, src1_sel_e s1, src2_sel_e s2,
                            logic pt);
        pc[l]         <= $urandom & 32'hffff_fffc;
        imm[l]        <= $urandom;
        rj[l]         <= reg_idx_t'(1 + $urandom % 31);
        rk[l]         <= reg_idx_t'(1 + $urandom % 31);
        rd[l]         <= reg_idx_t'($urandom % 8);
        rj_data[l]    <= $urandom;
        rk_data[l]    <= $urandom;
        alu_op[l]     <= op;
        br_op[l]      <= br;
        src1_sel[l]   <= s1;
        src2_sel[l]   <= s2;
        pred_taken[l] <= pt;
    endtask

    // holds the bundle one stalled cycle and then releases the pending sources
    task automatic wait_accept();
        @(negedge aclk);
        while (forward_stall_o) begin
            stalls++;
            @(posedge aclk);
            for (int s = 0; s < 3; s++) begin
                byp_vld[s][0] <= 1'b1;
                byp_vld[s][1] <= 1'b1;
            end
            @(negedge aclk);
        end
    endtask

    initial begin
        void'($urandom(32'h229260ae));
        aresetn     <= 1'b0;
        issue_valid <= 1'b0;
        pred_target <= '0;
        set_lane(0, ALU_ADD, BR_NONE, SRC1_RF, SRC2_RF, 1'b0);
        set_lane(1, ALU_ADD, BR_NONE, SRC1_RF, SRC2_RF, 1'b0);
        clear_bypass();
        repeat (16) @(posedge aclk);
        aresetn <= 1'b1;
        repeat (3) @(posedge aclk);

        // every ALU op against every operand source
        for (int op = 0; op < 12; op++) begin
            for (int a = 0; a < 3; a++) begin
                for (int b = 0; b < 2; b++) begin
                    @(posedge aclk);
                    issue_valid <= 1'b1;
                    clear_bypass();
                    set_lane(0, alu_op_e'(op), BR_NONE, src1_sel_e'(a), src2_sel_e'(b), 1'b0);
                    set_lane(1, alu_op_e'(op), BR_NONE, src1_sel_e'(2 - a),
                             src2_sel_e'(1 - b), 1'b0);
                    wait_accept();
                end
            end
        end

        // r9 replaces r7 in the newest k sources so k = 6 falls back to the rf
        for (int k = 0; k <= 6; k++) begin
            @(posedge aclk);
            set_lane(0, ALU_ADD, BR_NONE, SRC1_RF, SRC2_RF, 1'b0);
            set_lane(1, ALU_XOR, BR_NONE, SRC1_RF, SRC2_RF, 1'b0);
            rj[0] <= 5'd7;
            rk[0] <= 5'd7;
            rj[1] <= 5'd9;
            rk[1] <= 5'd7;
            for (int s = 0; s < 3; s++) begin
                for (int l = 0; l < 2; l++) begin
                    byp_rd[s][l]   <= (s * 2 + 1 - l >= k) ? 5'd7 : 5'd9;
                    byp_data[s][l] <= $urandom;
                    byp_vld[s][l]  <= 1'b1;
                end
            end
            wait_accept();
        end

        // r0 is written by every stage and still reads zero
        @(posedge aclk);
        set_lane(0, ALU_OR, BR_NONE, SRC1_RF, SRC2_RF, 1'b0);
        set_lane(1, ALU_ADD, BR_NONE, SRC1_RF, SRC2_RF, 1'b0);
        clear_bypass();
        rj[0] <= ZERO_REG;
        rk[0] <= ZERO_REG;
        rj[1] <= ZERO_REG;
        wait_accept();

        // pending newest match in mem lane 1 with a valid older copy in wb
        @(posedge aclk);
        set_lane(0, ALU_ADD, BR_NONE, SRC1_RF, SRC2_RF, 1'b0);
        set_lane(1, ALU_SUB, BR_NONE, SRC1_RF, SRC2_RF, 1'b0);
        clear_bypass();
        rj[0]         <= 5'd7;
        rk[1]         <= 5'd5;
        byp_rd[0][1]  <= 5'd7;
        byp_vld[0][1] <= 1'b0;
        byp_rd[2][0]  <= 5'd7;
        byp_rd[1][0]  <= 5'd5;
        byp_vld[1][0] <= 1'b0;
        wait_accept();

        // branches in either lane with both predictions and right and wrong targets
        for (int ln = 0; ln < 2; ln++) begin
            for (int br = 1; br < 9; br++) begin
                for (int pt = 0; pt < 2; pt++) begin
                    for (int good = 0; good < 2; good++) begin
                        for (int d = 0; d < 3; d++) begin
                            word_t pcv;
                            word_t immv;
                            word_t xv;
                            word_t yv;
                            word_t tgt;
                            pcv  = $urandom & 32'hffff_fffc;
                            immv = $urandom & 32'h0000_fffc;
                            xv   = (d == 2) ? 32'd9 : (d == 1) ? 32'hffff_fffd : 32'd5;
                            yv   = (d == 1) ? 32'd9 : (d == 2) ? 32'd3 : 32'd5;
                            tgt  = ((br == 8) ? xv : pcv) + immv;
                            @(posedge aclk);
                            clear_bypass();
                            set_lane(ln, ALU_ADD, br_op_e'(br), SRC1_RF, SRC2_IMM, pt != 0);
                            set_lane(1 - ln, ALU_OR, (ln == 0) ? BR_BNE : BR_NONE,
                                     SRC1_PC, SRC2_IMM, (ln == 0) && d != 0);
                            pc[ln]      <= pcv;
                            imm[ln]     <= immv;
                            rj_data[ln] <= xv;
                            rk_data[ln] <= yv;
                            pred_target <= (good != 0) ? tgt : tgt ^ 32'h40;
                            wait_accept();
                        end
                    end
                end
            end
        end

        // random bundles over a small register set so the bypass hits often
        for (int n = 0; n < N_RANDOM; n++) begin
            @(posedge aclk);
            issue_valid <= ($urandom % 10) != 0;
            pred_target <= $urandom;
            for (int l = 0; l < 2; l++) begin
                set_lane(l, alu_op_e'($urandom % 12), br_op_e'($urandom % 9),
                         src1_sel_e'($urandom % 3), src2_sel_e'($urandom % 2),
                         logic'($urandom % 2));
                rj[l] <= reg_idx_t'($urandom % 8);
                rk[l] <= reg_idx_t'($urandom % 8);
            end
            for (int s = 0; s < 3; s++) begin
                for (int l = 0; l < 2; l++) begin
                    byp_rd[s][l]   <= reg_idx_t'($urandom % 8);
                    byp_data[s][l] <= $urandom;
                    byp_vld[s][l]  <= ($urandom % 16) != 0;
                end
            end
            wait_accept();
        end

        @(posedge aclk);
        issue_valid <= 1'b0;
        repeat (3) @(posedge aclk);
        $display("bundles %0d, stall cycles %0d, errors %0d", bundles, stalls, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* tb.f */
ex_pkg.sv
ex_alu.sv
ex_bypass.sv
ex_lane.sv
ex_resolve.sv
ex_stage_top.sv
tb_ex_stage.sv
